// File: calculator_top.f
rtl/calc_data_pkg.sv
rtl/calc_ctrl_pkg.sv
rtl/key_entry.sv
rtl/sm_adder.sv
rtl/sm_multiplier.sv
rtl/gencon.sv
rtl/calculator_top.sv
verification/calculator_tb.sv

// File: rtl/calc_ctrl_pkg.sv
// Calculator control definitions
package calc_ctrl_pkg;

    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_INPUT_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_INPUT_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT_ADDSUB,
        SHOW_RESULT_MULT
    } state_t;

    // Cycles from add_start to add_done
    localparam int ADD_LATENCY = 2;

endpackage

// File: rtl/calc_data_pkg.sv
// Calculator data types and key codes
package calc_data_pkg;

    localparam int VALUE_W = 16;
    localparam int MAG_W   = VALUE_W - 1;

    // Sign-magnitude number with the sign in bit 15
    typedef logic [VALUE_W-1:0] value_t;
    typedef logic [MAG_W-1:0]   mag_t;
    typedef logic [3:0]         digit_t;
    typedef logic [2:0]         op_t;
    typedef logic [4:0]         key_code_t;

    localparam op_t OP_NONE = 3'd0;
    localparam op_t OP_NEG  = 3'd1;
    localparam op_t OP_ADD  = 3'd2;
    localparam op_t OP_SUB  = 3'd3;
    localparam op_t OP_MUL  = 3'd4;

    // Codes 0 to 9 are digit keys
    localparam key_code_t KEY_DIGIT_MAX = 5'd9;
    localparam key_code_t KEY_NEG       = 5'd16;
    localparam key_code_t KEY_ADD       = 5'd17;
    localparam key_code_t KEY_SUB       = 5'd18;
    localparam key_code_t KEY_MUL       = 5'd19;
    localparam key_code_t KEY_EQ        = 5'd20;

    // Each new digit shifts the operand one decimal place
    localparam value_t DIGIT_BASE = 16'd10;

endpackage

// File: rtl/calculator_top.sv
// Pocket calculator core
module calculator_top #(
    parameter int MUL_STEPS = 15
) (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     key_press,
    input  calc_data_pkg::key_code_t key_code,
    output calc_data_pkg::value_t    display_output,
    output logic                     complete
);

    logic                  read_input;
    logic                  key_read;
    logic                  equal_input;
    calc_data_pkg::digit_t keypad_input;
    calc_data_pkg::op_t    operator_input;

    calc_data_pkg::value_t add_a;
    calc_data_pkg::value_t add_b;
    calc_data_pkg::value_t add_sum;
    logic                  sub;
    logic                  add_start;
    logic                  add_done;

    calc_data_pkg::value_t mul_a;
    calc_data_pkg::value_t mul_b;
    calc_data_pkg::value_t mul_prod;
    logic                  mul_start;
    logic                  mul_done;

    key_entry u_key_entry (.*);

    gencon u_gencon (.*);

    sm_adder u_adder (.*);

    sm_multiplier #(
        .MUL_STEPS(MUL_STEPS)
    ) u_multiplier (.*);

endmodule

// File: rtl/gencon.sv
// Calculator control FSM
module gencon (
    input  logic                  clk,
    input  logic                  nRST,

    input  calc_data_pkg::digit_t keypad_input,
    input  logic                  read_input,
    input  calc_data_pkg::op_t    operator_input,
    input  logic                  equal_input,

    output logic                  key_read,
    output logic                  complete,
    output calc_data_pkg::value_t display_output,

    output calc_data_pkg::value_t add_a,
    output calc_data_pkg::value_t add_b,
    output logic                  sub,
    output logic                  add_start,
    input  calc_data_pkg::value_t add_sum,
    input  logic                  add_done,

    output calc_data_pkg::value_t mul_a,
    output calc_data_pkg::value_t mul_b,
    output logic                  mul_start,
    input  calc_data_pkg::value_t mul_prod,
    input  logic                  mul_done
);

    calc_ctrl_pkg::state_t state;
    calc_ctrl_pkg::state_t next_state;

    calc_data_pkg::value_t operand1;
    calc_data_pkg::value_t operand2;
    calc_data_pkg::op_t    latched_op;
    calc_data_pkg::digit_t latched_digit;
    calc_data_pkg::mag_t   digit_mag;
    logic                  op_is_binary;
    logic                  negate;

    assign op_is_binary = (operator_input == calc_data_pkg::OP_ADD) ||
                          (operator_input == calc_data_pkg::OP_SUB) ||
                          (operator_input == calc_data_pkg::OP_MUL);
    assign negate       = operator_input == calc_data_pkg::OP_NEG;
    assign digit_mag    = calc_data_pkg::mag_t'(latched_digit);

    always_comb begin
        next_state = state;
        case (state)
            calc_ctrl_pkg::WAIT_OP1:
                if (op_is_binary) begin
                    next_state = calc_ctrl_pkg::WAIT_OP2;
                end else if (read_input) begin
                    next_state = calc_ctrl_pkg::WAIT_MULT_OP1;
                end
            calc_ctrl_pkg::WAIT_MULT_OP1:
                if (mul_done) begin
                    next_state = calc_ctrl_pkg::ADD_KEY_INPUT_OP1;
                end
            calc_ctrl_pkg::ADD_KEY_INPUT_OP1:
                next_state = calc_ctrl_pkg::WAIT_OP1;
            calc_ctrl_pkg::WAIT_OP2:
                if (equal_input) begin
                    next_state = calc_ctrl_pkg::SEND_TO_COMPUTE;
                end else if (read_input) begin
                    next_state = calc_ctrl_pkg::WAIT_MULT_OP2;
                end
            calc_ctrl_pkg::WAIT_MULT_OP2:
                if (mul_done) begin
                    next_state = calc_ctrl_pkg::ADD_KEY_INPUT_OP2;
                end
            calc_ctrl_pkg::ADD_KEY_INPUT_OP2:
                next_state = calc_ctrl_pkg::WAIT_OP2;
            calc_ctrl_pkg::SEND_TO_COMPUTE:
                next_state = calc_ctrl_pkg::WAIT_COMPUTE;
            calc_ctrl_pkg::WAIT_COMPUTE:
                if (add_done) begin
                    next_state = calc_ctrl_pkg::SHOW_RESULT_ADDSUB;
                end else if (mul_done) begin
                    next_state = calc_ctrl_pkg::SHOW_RESULT_MULT;
                end
            default:
                next_state = calc_ctrl_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= calc_ctrl_pkg::WAIT_OP1;
            key_read       <= 1'b0;
            add_start      <= 1'b0;
            mul_start      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
            operand1       <= '0;
            operand2       <= '0;
            latched_op     <= calc_data_pkg::OP_NONE;
        end else begin
            state     <= next_state;
            key_read  <= 1'b0;
            add_start <= 1'b0;
            mul_start <= 1'b0;
            complete  <= 1'b0;
            case (state)
                calc_ctrl_pkg::WAIT_OP1: begin
                    if (negate) begin
                        operand1[15] <= ~operand1[15];
                    end
                    if (op_is_binary) begin
                        latched_op <= operator_input;
                    end else if (read_input) begin
                        key_read  <= 1'b1;
                        mul_start <= 1'b1;
                    end
                end
                calc_ctrl_pkg::WAIT_MULT_OP1:
                    if (mul_done) begin
                        operand1 <= mul_prod;
                    end
                calc_ctrl_pkg::ADD_KEY_INPUT_OP1:
                    operand1 <= {operand1[15], operand1[14:0] + digit_mag};
                calc_ctrl_pkg::WAIT_OP2: begin
                    if (negate) begin
                        operand2[15] <= ~operand2[15];
                    end
                    // Start goes out while in SEND_TO_COMPUTE
                    if (equal_input) begin
                        add_start <= latched_op != calc_data_pkg::OP_MUL;
                        mul_start <= latched_op == calc_data_pkg::OP_MUL;
                    end else if (read_input) begin
                        key_read  <= 1'b1;
                        mul_start <= 1'b1;
                    end
                end
                calc_ctrl_pkg::WAIT_MULT_OP2:
                    if (mul_done) begin
                        operand2 <= mul_prod;
                    end
                calc_ctrl_pkg::ADD_KEY_INPUT_OP2:
                    operand2 <= {operand2[15], operand2[14:0] + digit_mag};
                calc_ctrl_pkg::WAIT_COMPUTE:
                    if (add_done) begin
                        display_output <= add_sum;
                        complete       <= 1'b1;
                    end else if (mul_done) begin
                        display_output <= mul_prod;
                        complete       <= 1'b1;
                    end
                // Result becomes the first operand of the next calculation
                calc_ctrl_pkg::SHOW_RESULT_ADDSUB: begin
                    operand1 <= add_sum;
                    operand2 <= '0;
                end
                calc_ctrl_pkg::SHOW_RESULT_MULT: begin
                    operand1 <= mul_prod;
                    operand2 <= '0;
                end
                default: ;
            endcase
        end
    end

    // Operands and digit for the arithmetic units
    always_ff @(posedge clk) begin
        if (state == calc_ctrl_pkg::WAIT_OP1 && read_input) begin
            latched_digit <= keypad_input;
            mul_a         <= operand1;
            mul_b         <= calc_data_pkg::DIGIT_BASE;
        end else if (state == calc_ctrl_pkg::WAIT_OP2) begin
            if (equal_input) begin
                add_a <= operand1;
                add_b <= operand2;
                sub   <= latched_op == calc_data_pkg::OP_SUB;
                mul_a <= operand1;
                mul_b <= operand2;
            end else if (read_input) begin
                latched_digit <= keypad_input;
                mul_a         <= operand2;
                mul_b         <= calc_data_pkg::DIGIT_BASE;
            end
        end
    end

    // Key entry only produces defined operator codes
    assert property (@(posedge clk) disable iff (!nRST)
        operator_input <= calc_data_pkg::OP_MUL);

endmodule

// File: rtl/key_entry.sv
// Keypad code decoder
module key_entry (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     key_press,
    input  calc_data_pkg::key_code_t key_code,
    input  logic                     key_read,
    output logic                     read_input,
    output calc_data_pkg::digit_t    keypad_input,
    output calc_data_pkg::op_t       operator_input,
    output logic                     equal_input
);

    logic               is_digit;
    logic               take_digit;
    calc_data_pkg::op_t key_op;

    assign is_digit   = key_code <= calc_data_pkg::KEY_DIGIT_MAX;
    // Presses during a pending digit are lost
    assign take_digit = key_press && is_digit && !read_input;

    always_comb begin
        case (key_code)
            calc_data_pkg::KEY_NEG: key_op = calc_data_pkg::OP_NEG;
            calc_data_pkg::KEY_ADD: key_op = calc_data_pkg::OP_ADD;
            calc_data_pkg::KEY_SUB: key_op = calc_data_pkg::OP_SUB;
            calc_data_pkg::KEY_MUL: key_op = calc_data_pkg::OP_MUL;
            default:                key_op = calc_data_pkg::OP_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            read_input     <= 1'b0;
            operator_input <= calc_data_pkg::OP_NONE;
            equal_input    <= 1'b0;
        end else begin
            if (key_read) begin
                read_input <= 1'b0;
            end else if (take_digit) begin
                read_input <= 1'b1;
            end
            operator_input <= key_press ? key_op : calc_data_pkg::OP_NONE;
            equal_input    <= key_press && (key_code == calc_data_pkg::KEY_EQ);
        end
    end

    always_ff @(posedge clk) begin
        if (take_digit) begin
            keypad_input <= calc_data_pkg::digit_t'(key_code[3:0]);
        end
    end

    // Acknowledge only for an outstanding request
    assert property (@(posedge clk) disable iff (!nRST)
        key_read |-> read_input);

endmodule

// File: rtl/sm_adder.sv
// Sign-magnitude adder and subtractor
module sm_adder (
    input  logic                  clk,
    input  logic                  nRST,
    input  calc_data_pkg::value_t add_a,
    input  calc_data_pkg::value_t add_b,
    input  logic                  sub,
    input  logic                  add_start,
    output calc_data_pkg::value_t add_sum,
    output logic                  add_done
);

    localparam int LAT = calc_ctrl_pkg::ADD_LATENCY;

    logic [LAT-1:0]       done_pipe;
    logic                 a_sign;
    logic                 b_sign;
    calc_data_pkg::mag_t  a_mag;
    calc_data_pkg::mag_t  b_mag;
    logic                 res_sign;
    calc_data_pkg::mag_t  res_mag;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            done_pipe <= '0;
        end else begin
            done_pipe <= {done_pipe[LAT-2:0], add_start};
        end
    end

    assign add_done = done_pipe[LAT-1];

    // Stage one flips the sign of b for subtract
    always_ff @(posedge clk) begin
        if (add_start) begin
            a_sign <= add_a[15];
            a_mag  <= add_a[14:0];
            b_sign <= add_b[15] ^ sub;
            b_mag  <= add_b[14:0];
        end
    end

    always_comb begin
        if (a_sign == b_sign) begin
            res_mag  = a_mag + b_mag;
            res_sign = a_sign;
        end else if (a_mag >= b_mag) begin
            res_mag  = a_mag - b_mag;
            res_sign = a_sign;
        end else begin
            res_mag  = b_mag - a_mag;
            res_sign = b_sign;
        end
    end

    // Stage two forces a zero result positive
    always_ff @(posedge clk) begin
        if (done_pipe[0]) begin
            add_sum <= {res_sign && (res_mag != '0), res_mag};
        end
    end

endmodule

// File: rtl/sm_multiplier.sv
// Iterative sign-magnitude multiplier
module sm_multiplier #(
    parameter int MUL_STEPS = 15
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  calc_data_pkg::value_t mul_a,
    input  calc_data_pkg::value_t mul_b,
    input  logic                  mul_start,
    output calc_data_pkg::value_t mul_prod,
    output logic                  mul_done
);

    localparam int CNT_W = $clog2(MUL_STEPS + 1);

    logic                busy;
    logic [CNT_W-1:0]    steps_left;
    logic                last_step;
    logic                prod_sign;
    calc_data_pkg::mag_t acc;
    calc_data_pkg::mag_t a_sh;
    calc_data_pkg::mag_t b_sh;
    calc_data_pkg::mag_t partial;
    calc_data_pkg::mag_t acc_next;

    assign last_step = busy && (steps_left == CNT_W'(1));
    assign partial   = b_sh[0] ? a_sh : '0;
    // Carries past bit 14 drop out here
    assign acc_next  = acc + partial;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            steps_left <= '0;
            mul_done   <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                busy       <= 1'b1;
                steps_left <= CNT_W'(MUL_STEPS);
            end else if (busy) begin
                steps_left <= steps_left - 1'b1;
                if (last_step) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // One multiplier bit per cycle, low bit first
    always_ff @(posedge clk) begin
        if (mul_start) begin
            acc       <= '0;
            a_sh      <= mul_a[14:0];
            b_sh      <= mul_b[14:0];
            prod_sign <= mul_a[15] ^ mul_b[15];
        end else if (busy) begin
            acc  <= acc_next;
            a_sh <= a_sh << 1;
            b_sh <= b_sh >> 1;
            if (last_step) begin
                mul_prod <= {prod_sign && (acc_next != '0), acc_next};
            end
        end
    end

    // Controller waits for mul_done before the next start
    assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> !busy);

endmodule

// File: verification/calculator_tb.sv
// Calculator core testbench
module calculator_tb;

    localparam int CLK_PERIOD       = 20;
    localparam int MUL_STEPS        = 15;
    localparam int KEY_GAP          = 40;
    localparam int DIRECTED_PRESSES = 60;
    localparam int RANDOM_PAIRS     = 20;
    localparam int PAIR_PRESSES     = 12;
    // Each press takes well under 60 cycles
    localparam int TIMEOUT_CYCLES   =
        (DIRECTED_PRESSES + RANDOM_PAIRS * PAIR_PRESSES) * 60 + 2000;

    logic                     clk;
    logic                     nRST;
    logic                     key_press;
    calc_data_pkg::key_code_t key_code;
    calc_data_pkg::value_t    display_output;
    logic                     complete;

    int     complete_count;
    int     error_count;
    integer seed;

    calculator_top #(
        .MUL_STEPS(MUL_STEPS)
    ) uut (
        .clk(clk),
        .nRST(nRST),
        .key_press(key_press),
        .key_code(key_code),
        .display_output(display_output),
        .complete(complete)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // One count per complete pulse
    always @(negedge clk) begin
        if (complete) begin
            complete_count <= complete_count + 1;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    // Sign-magnitude result with the magnitude wrapped modulo 32768
    function automatic calc_data_pkg::value_t calc_expected(input int a, input int b,
                                                            input calc_data_pkg::key_code_t op);
        longint                r;
        longint                m;
        calc_data_pkg::value_t v;
        case (op)
            calc_data_pkg::KEY_ADD: r = longint'(a) + b;
            calc_data_pkg::KEY_SUB: r = longint'(a) - b;
            default:                r = longint'(a) * b;
        endcase
        m = (r < 0) ? -r : r;
        m = m % 32768;
        v[14:0] = m[14:0];
        v[15]   = (r < 0) && (m != 0);
        return v;
    endfunction

    function automatic int to_int(input calc_data_pkg::value_t v);
        int mag;
        mag = v[14:0];
        if (v[15]) begin
            mag = -mag;
        end
        return mag;
    endfunction

    function automatic int random_operand();
        int mag;
        mag = {$random(seed)} % 10000;
        if ($random(seed) & 1) begin
            mag = -mag;
        end
        return mag;
    endfunction

    function automatic calc_data_pkg::key_code_t random_op();
        calc_data_pkg::key_code_t op;
        case ({$random(seed)} % 3)
            0:       op = calc_data_pkg::KEY_ADD;
            1:       op = calc_data_pkg::KEY_SUB;
            default: op = calc_data_pkg::KEY_MUL;
        endcase
        return op;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at time %0t: %s expected %h, got %h", $time, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        nRST = 1'b0;
        idle_cycles(5);
        nRST = 1'b1;
        idle_cycles(2);
    endtask

    // One-cycle key strobe
    task automatic drive_key(input calc_data_pkg::key_code_t code);
        @(negedge clk);
        key_press = 1'b1;
        key_code  = code;
        @(negedge clk);
        key_press = 1'b0;
        key_code  = '0;
    endtask

    task automatic press_key(input calc_data_pkg::key_code_t code);
        drive_key(code);
        idle_cycles(KEY_GAP);
    endtask

    task automatic enter_number(input int value);
        int mag;
        int digits[5];
        int n;
        int i;
        mag = (value < 0) ? -value : value;
        n   = 0;
        do begin
            digits[n] = mag % 10;
            mag       = mag / 10;
            n++;
        end while (mag > 0 && n < 5);
        // Most significant digit first
        for (i = n - 1; i >= 0; i--) begin
            press_key(calc_data_pkg::key_code_t'(digits[i]));
        end
        if (value < 0) begin
            press_key(calc_data_pkg::KEY_NEG);
        end
    endtask

    task automatic wait_complete();
        int   i;
        logic seen;
        seen = 1'b0;
        for (i = 0; i < MUL_STEPS + 20 && !seen; i++) begin
            @(negedge clk);
            seen = complete;
        end
        if (!seen) begin
            error_count++;
            $display("No complete pulse came after the equals key (time %0t)", $time);
            $display("Test failed");
            $fatal(1, "Result never shown");
        end
    endtask

    task automatic finish_calc(input calc_data_pkg::value_t expected, input string what);
        int count_before;
        count_before = complete_count;
        drive_key(calc_data_pkg::KEY_EQ);
        wait_complete();
        check_value(display_output, expected, what);
        idle_cycles(KEY_GAP);
        check_value(complete_count, count_before + 1, {what, " complete pulses"});
    endtask

    task automatic run_calc(input int a, input calc_data_pkg::key_code_t op, input int b,
                            input string what);
        enter_number(a);
        press_key(op);
        enter_number(b);
        finish_calc(calc_expected(a, b, op), what);
    endtask

    task automatic idle_after_reset();
        int count_before;
        apply_reset();
        count_before = complete_count;
        idle_cycles(20);
        check_value(display_output, 16'h0000, "display after reset");
        check_value(complete, 1'b0, "complete while idle");
        check_value(complete_count, count_before, "complete pulses while idle");
    endtask

    task automatic add_and_subtract();
        apply_reset();
        run_calc(123, calc_data_pkg::KEY_ADD, 45, "123 + 45");
        apply_reset();
        run_calc(12, calc_data_pkg::KEY_SUB, 50, "12 - 50");
        apply_reset();
        run_calc(-7, calc_data_pkg::KEY_ADD, 20, "-7 + 20");
        apply_reset();
        run_calc(-5, calc_data_pkg::KEY_ADD, 5, "-5 + 5");
    endtask

    task automatic multiply_cases();
        apply_reset();
        run_calc(300, calc_data_pkg::KEY_MUL, 200, "300 * 200");
        apply_reset();
        run_calc(-12, calc_data_pkg::KEY_MUL, 34, "-12 * 34");
        apply_reset();
        run_calc(300, calc_data_pkg::KEY_MUL, -200, "300 * -200");
    endtask

    // Previous result stays as operand one
    task automatic chained_calculations();
        calc_data_pkg::value_t result;
        apply_reset();
        run_calc(5, calc_data_pkg::KEY_ADD, 6, "5 + 6");
        result = calc_expected(5, 6, calc_data_pkg::KEY_ADD);
        press_key(calc_data_pkg::KEY_MUL);
        enter_number(7);
        result = calc_expected(to_int(result), 7, calc_data_pkg::KEY_MUL);
        finish_calc(result, "chained * 7");
        press_key(calc_data_pkg::KEY_SUB);
        enter_number(80);
        result = calc_expected(to_int(result), 80, calc_data_pkg::KEY_SUB);
        finish_calc(result, "chained - 80");
    endtask

    task automatic random_sweep();
        int                       i;
        int                       a;
        int                       b;
        calc_data_pkg::key_code_t op;
        for (i = 0; i < RANDOM_PAIRS; i++) begin
            a  = random_operand();
            b  = random_operand();
            op = random_op();
            apply_reset();
            run_calc(a, op, b, $sformatf("random pair %0d (%0d, %0d)", i, a, b));
        end
    endtask

    initial begin
        seed           = 32'hbfc455ce;
        nRST           = 1'b0;
        key_press      = 1'b0;
        key_code       = '0;
        complete_count = 0;
        error_count    = 0;
        idle_after_reset();
        add_and_subtract();
        multiply_cases();
        chained_calculations();
        random_sweep();
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
